// ==== Bender.yml ====
package:
  name: uart_tx_unit

sources:
  # design
  - files:
      - design/uart_line_pkg.sv
      - design/uart_buf_pkg.sv
      - design/tx_fifo.sv
      - design/baud_timer.sv
      - design/tx_shift_reg.sv
      - design/tx_bit_fsm.sv
      - design/uart_tx_unit.sv
  # tb
  - target: simulation
    files:
      - tb/tb_uart_tx_unit.sv

// ==== design/baud_timer.sv ====
`timescale 1ns/10ps

module baud_timer #(
    parameter logic [31:0] clk_per_half_bit = uart_line_pkg::default_clk_per_half_bit
) (
    input  logic clk_uart,
    input  logic rstn,
    input  logic run,
    output logic bit_tick
);
    // one full bit in clk_uart cycles
    localparam int unsigned period = 2 * clk_per_half_bit;
    // holds period - 1
    localparam int cnt_w = $clog2(period);
    localparam logic [cnt_w-1:0] reload = cnt_w'(period - 1);

    logic [cnt_w-1:0] cnt;

    // last cycle of the bit period
    assign bit_tick = run && (cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // down counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_uart) begin
        if (!rstn) begin
            cnt <= reload;
        end else if (!run) begin
            // parked at full period so the first tick
            // lands period cycles after run rises
            cnt <= reload;
        end else if (bit_tick) begin
            // next bit starts right away
            cnt <= reload;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== design/tx_bit_fsm.sv ====
`timescale 1ns/10ps

module tx_bit_fsm (
    input  logic clk_uart,
    input  logic rstn,
    input  logic tx_start,
    input  logic bit_tick,
    input  logic bit_out,
    output logic load,
    output logic shift,
    output logic timer_run,
    output logic busy,
    output logic txd
);
    import uart_line_pkg::*;

    tx_state_t            state;
    // data bit currently on the line
    logic [bit_idx_w-1:0] bit_idx;

    // frame in progress
    assign busy      = (state != tx_idle);
    // timer counts only inside a frame
    assign timer_run = (state != tx_idle);

    // byte captured on the launch cycle
    assign load = (state == tx_idle) && tx_start;

    // shift at the end of the start bit and every data bit
    // so bit_out already holds the next bit when txd updates
    assign shift = bit_tick && ((state == tx_start_bit) || (state == tx_data_bit));

    ////////////////////////////////////////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_uart) begin
        if (!rstn) begin
            state   <= tx_idle;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                tx_idle: begin
                    bit_idx <= '0;
                    // start bit goes out the next cycle
                    if (tx_start) begin
                        state <= tx_start_bit;
                        txd   <= 1'b0;
                    end
                end
                tx_start_bit: begin
                    // first data bit, lsb
                    if (bit_tick) begin
                        state <= tx_data_bit;
                        txd   <= bit_out;
                    end
                end
                tx_data_bit: begin
                    if (bit_tick) begin
                        if (bit_idx == bit_idx_w'(data_bits - 1)) begin
                            // all data bits sent
                            state <= tx_stop_bit;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= bit_out;
                        end
                    end
                end
                tx_stop_bit: begin
                    // busy drops the cycle after this tick
                    if (bit_tick) begin
                        state <= tx_idle;
                        txd   <= 1'b1;
                    end
                end
                default: begin
                    state <= tx_idle;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== design/tx_fifo.sv ====
`timescale 1ns/10ps

module tx_fifo (
    input  logic                                clk_uart,
    input  logic                                rstn,
    input  logic                                wr_en,
    input  logic [uart_line_pkg::data_bits-1:0] din,
    input  logic                                rd_en,
    output logic [uart_line_pkg::data_bits-1:0] dout,
    output logic                                full,
    output logic                                empty
);
    import uart_line_pkg::*;
    import uart_buf_pkg::*;

    // byte storage
    logic [data_bits-1:0]  mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    // accepted requests only
    logic                  do_wr;
    logic                  do_rd;

    // write while full is dropped
    assign do_wr = wr_en && !full;
    // read while empty is ignored
    assign do_rd = rd_en && !empty;

    // status straight from the fill count
    assign full  = (count == fifo_cnt_w'(fifo_depth));
    assign empty = (count == '0);

    ////////////////////////////////////////////////////////////////////////////
    // data path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_uart) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // oldest byte shows on dout the cycle after a read
    always_ff @(posedge clk_uart) begin
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and fill count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_uart) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous write and read keeps the count
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/tx_shift_reg.sv ====
`timescale 1ns/10ps

module tx_shift_reg (
    input  logic                                clk_uart,
    input  logic                                rstn,
    input  logic                                load,
    input  logic                                shift,
    input  logic [uart_line_pkg::data_bits-1:0] data,
    output logic                                bit_out
);
    import uart_line_pkg::*;

    // byte in flight
    logic [data_bits-1:0] sreg;

    // lsb goes out first
    assign bit_out = sreg[0];

    ////////////////////////////////////////////////////////////////////////////
    // load and shift
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_uart) begin
        if (!rstn) begin
            // all ones looks like an idle line
            sreg <= '1;
        end else if (load) begin
            // capture the fetched byte
            sreg <= data;
        end else if (shift) begin
            // move toward lsb, ones fill from the top
            sreg <= {1'b1, sreg[data_bits-1:1]};
        end
    end

endmodule

// ==== design/uart_buf_pkg.sv ====
package uart_buf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // transmit buffer
    ////////////////////////////////////////////////////////////////////////////

    // bytes held while the line is busy
    localparam int fifo_depth = 16;

    // pointer wraps at fifo_depth
    localparam int fifo_ptr_w = 4;

    // one extra bit so a full buffer is countable
    localparam int fifo_cnt_w = 5;

    // fifo read, transmitter launch, then back to idle
    typedef enum logic [1:0] {
        fetch_idle   = 2'b00,
        fetch_read   = 2'b01,
        fetch_launch = 2'b10
    } fetch_state_t;

endpackage

// ==== design/uart_line_pkg.sv ====
package uart_line_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // serial frame format
    ////////////////////////////////////////////////////////////////////////////

    // clk_uart cycles per half bit at the default rate
    localparam logic [31:0] default_clk_per_half_bit = 32'd5208;

    // data bits in one frame
    localparam int data_bits = 8;

    // enough to count data_bits positions
    localparam int bit_idx_w = 3;

    ////////////////////////////////////////////////////////////////////////////
    // bit sequencer
    ////////////////////////////////////////////////////////////////////////////

    // one start bit, data lsb first, one stop bit
    typedef enum logic [1:0] {
        // line parked high
        tx_idle      = 2'b00,
        // line low for one bit period
        tx_start_bit = 2'b01,
        // shift register lsb on the line
        tx_data_bit  = 2'b10,
        // line high for one bit period
        tx_stop_bit  = 2'b11
    } tx_state_t;

endpackage

// ==== design/uart_tx_unit.sv ====
`timescale 1ns/10ps

module uart_tx_unit #(
    parameter logic [31:0] clk_per_half_bit = uart_line_pkg::default_clk_per_half_bit
) (
    input  logic                                clk_uart,
    input  logic                                rstn,
    input  logic                                wr_en,
    input  logic [uart_line_pkg::data_bits-1:0] din,
    output logic                                full,
    output logic                                txd
);
    import uart_line_pkg::*;
    import uart_buf_pkg::*;

    // fifo head byte
    logic [data_bits-1:0] sdata;
    logic                 empty;
    logic                 rd_en;
    logic                 tx_start;
    logic                 busy;
    // transmitter internals
    logic                 load;
    logic                 shift;
    logic                 timer_run;
    logic                 bit_tick;
    logic                 bit_out;
    fetch_state_t         fetch_state;

    tx_fifo fifo (
        .clk_uart (clk_uart),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .din      (din),
        .rd_en    (rd_en),
        .dout     (sdata),
        .full     (full),
        .empty    (empty)
    );

    tx_bit_fsm bit_fsm (
        .clk_uart  (clk_uart),
        .rstn      (rstn),
        .tx_start  (tx_start),
        .bit_tick  (bit_tick),
        .bit_out   (bit_out),
        .load      (load),
        .shift     (shift),
        .timer_run (timer_run),
        .busy      (busy),
        .txd       (txd)
    );

    baud_timer #(
        .clk_per_half_bit (clk_per_half_bit)
    ) timer (
        .clk_uart (clk_uart),
        .rstn     (rstn),
        .run      (timer_run),
        .bit_tick (bit_tick)
    );

    tx_shift_reg shifter (
        .clk_uart (clk_uart),
        .rstn     (rstn),
        .load     (load),
        .shift    (shift),
        .data     (sdata),
        .bit_out  (bit_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // fetch sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_uart) begin
        if (!rstn) begin
            fetch_state <= fetch_idle;
            rd_en       <= 1'b0;
            tx_start    <= 1'b0;
        end else begin
            case (fetch_state)
                fetch_read: begin
                    // dout valid next cycle, launch then
                    fetch_state <= fetch_launch;
                    rd_en       <= 1'b0;
                    tx_start    <= 1'b1;
                end
                fetch_launch: begin
                    // busy is high by the time we are idle again
                    fetch_state <= fetch_idle;
                    rd_en       <= 1'b0;
                    tx_start    <= 1'b0;
                end
                default: begin
                    tx_start <= 1'b0;
                    // byte waiting and line free
                    if (!empty && !busy) begin
                        fetch_state <= fetch_read;
                        rd_en       <= 1'b1;
                    end else begin
                        fetch_state <= fetch_idle;
                        rd_en       <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== filelist.f ====
design/uart_line_pkg.sv
design/uart_buf_pkg.sv
design/tx_fifo.sv
design/baud_timer.sv
design/tx_shift_reg.sv
design/tx_bit_fsm.sv
design/uart_tx_unit.sv
tb/tb_uart_tx_unit.sv

// ==== tb/tb_uart_tx_unit.sv ====
`timescale 1ns/10ps

module tb_uart_tx_unit;
    logic        clk_uart = 1'b0;
    logic        rstn;
    logic        wr_en;
    logic [7:0]  din;
    logic        full;
    logic        txd;

    // test records with all bytes stored flat
    string       t_name[$];
    string       t_mode[$];
    int          t_cnt[$];
    logic [7:0]  t_bytes[$];
    // decoded frames and the cycle each start bit was seen
    logic [7:0]  rx_q[$];
    int          rx_start[$];
    string       cur_name = "reset_idle";
    int          cycles = 0;
    int          limit = 2000;
    int          errors = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    uart_tx_unit #(.clk_per_half_bit(32'd4)) UUT (
        .clk_uart (clk_uart),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .din      (din),
        .full     (full),
        .txd      (txd)
    );

    always #50 clk_uart = ~clk_uart;

    always @(posedge clk_uart) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("error: transmitter stopped sending in test %s", cur_name);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch in %s: expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test file
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_tests();
        int                 fd;
        int                 r;
        int                 n;
        string              tok;
        string              mode;
        logic [8*128-1:0]   line;
        logic [7:0]         b;
        logic [31:0]        seed;
        seed = 32'hca3a_fc5e;
        fd = $fopen("tb/uart_tx_tests.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the test file");
            fail_cnt++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                // skip the rest of a comment line
                if (tok.substr(0, 0) == "#") begin
                    r = $fgets(line, fd);
                end else begin
                    r = $fscanf(fd, "%s %d", mode, n);
                    t_name.push_back(tok);
                    t_mode.push_back(mode);
                    t_cnt.push_back(n);
                    for (int i = 0; i < n; i++) begin
                        // random bytes come from the lcg and the rest from the file
                        if (mode == "random") begin
                            seed = lcg_next(seed);
                            b = seed[23:16];
                        end else begin
                            r = $fscanf(fd, "%h", b);
                        end
                        t_bytes.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // serial decoder sampling near mid-bit on negedge
    ////////////////////////////////////////////////////////////////////////////

    initial begin : serial_decoder
        logic       prev;
        logic [7:0] data;
        int         start_cyc;
        prev = 1'b1;
        forever begin
            @(negedge clk_uart);
            if (prev === 1'b1 && txd === 1'b0) begin
                start_cyc = cycles;
                // 4 more negedges puts us mid start bit
                repeat (4) @(negedge clk_uart);
                if (txd !== 1'b0) begin
                    $display("error: start bit not low in test %s", cur_name);
                    errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (8) @(negedge clk_uart);
                    data[i] = txd;
                end
                repeat (8) @(negedge clk_uart);
                if (txd !== 1'b1) begin
                    $display("error: stop bit not high in test %s", cur_name);
                    errors++;
                end
                rx_q.push_back(data);
                rx_start.push_back(start_cyc);
            end
            prev = txd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // one test record
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_test(input int t, input int off);
        logic [7:0] exp_q[$];
        int         errs_before;
        bit         full_seen;
        errs_before = errors;
        full_seen = 1'b0;
        cur_name = t_name[t];
        rx_q.delete();
        rx_start.delete();
        for (int i = 0; i < t_cnt[t]; i++) begin
            @(posedge clk_uart);
            wr_en <= 1'b1;
            din   <= t_bytes[off + i];
            // a write counts only when full was low in its cycle
            @(negedge clk_uart);
            if (full) begin
                full_seen = 1'b1;
            end else begin
                exp_q.push_back(t_bytes[off + i]);
            end
            if (t_mode[t] == "spaced") begin
                @(posedge clk_uart);
                wr_en <= 1'b0;
                while (rx_q.size() < exp_q.size()) @(negedge clk_uart);
            end
        end
        @(posedge clk_uart);
        wr_en <= 1'b0;
        while (rx_q.size() < exp_q.size()) @(negedge clk_uart);
        // room for a repeated frame to show up
        repeat (120) @(negedge clk_uart);
        compare_value({cur_name, " byte count"}, exp_q.size(), rx_q.size());
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            compare_value(cur_name, exp_q[i], rx_q[i]);
        end
        // queued frames start at most 80 + 4 cycles apart
        if (t_mode[t] != "spaced") begin
            for (int i = 1; i < rx_start.size(); i++) begin
                if (rx_start[i] - rx_start[i - 1] > 84) begin
                    $display("error: gap of %0d cycles between frames in test %s",
                             rx_start[i] - rx_start[i - 1] - 80, cur_name);
                    errors++;
                end
            end
        end
        // only the first byte leaves for the transmitter before the fifo fills
        if (t_mode[t] == "overfill") begin
            compare_value({cur_name, " accepted writes"}, uart_buf_pkg::fifo_depth + 1,
                          exp_q.size());
        end
        if (t_mode[t] == "overfill" && !full_seen) begin
            $display("error: full never went high in test %s", cur_name);
            errors++;
        end else if (t_mode[t] != "overfill" && exp_q.size() != t_cnt[t]) begin
            $display("error: a write was refused while the FIFO had room in test %s",
                     cur_name);
            errors++;
        end
        if (errors == errs_before) begin
            pass_cnt++;
            $display("test %s (%s): pass", cur_name, t_mode[t]);
        end else begin
            fail_cnt++;
            $display("test %s (%s): fail", cur_name, t_mode[t]);
        end
    endtask

    initial begin : main_flow
        int  off;
        bit  idle_bad;
        rstn  = 1'b0;
        wr_en = 1'b0;
        din   = 8'h00;
        idle_bad = 1'b0;
        load_tests();
        // every byte gets a frame plus slack
        limit = t_bytes.size() * 80 + 2000;
        repeat (16) @(posedge clk_uart);
        rstn <= 1'b1;
        // line parked high with nothing written
        repeat (100) begin
            @(negedge clk_uart);
            if (txd !== 1'b1) begin
                idle_bad = 1'b1;
            end
        end
        if (idle_bad || rx_q.size() != 0) begin
            $display("error: txd left the idle level after reset");
            fail_cnt++;
            $display("test reset_idle: fail");
        end else begin
            pass_cnt++;
            $display("test reset_idle: pass");
        end
        off = 0;
        for (int t = 0; t < t_name.size(); t++) begin
            run_test(t, off);
            off += t_cnt[t];
        end
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/uart_tx_tests.txt ====
# columns: test name, mode, byte count, then that many bytes in hex
# random records list no bytes, they come from the lcg
spaced_edges spaced 5
00 ff 55 aa 81
burst_ten burst 10
01 02 04 08 10
20 40 80 3c c3
overfill_twenty overfill 20
a0 a1 a2 a3 a4
a5 a6 a7 a8 a9
aa ab ac ad ae
af b0 b1 b2 b3
random_twelve random 12
